/* turf_ctrl_cfg.svh */
`ifndef TURF_CTRL_CFG_SVH
`define TURF_CTRL_CFG_SVH

// Register bus geometry
`define TURF_ADDR_W         16
`define TURF_DATA_W         32
`define TURF_SLV_ADDR_W     12

// Values of address bits 15..12
`define TURF_SEL_ID         4'h0
`define TURF_SEL_TIME       4'h1

// Identity words
`define TURF_IDENT          32'h54555246
`define TURF_VER_MAJOR      4'd0
`define TURF_VER_MINOR      4'd8
`define TURF_VER_REV        8'd14
`define TURF_FW_DATE        15'h2A3C
// Top bit stays 0 for revision A boards
`define TURF_DATEVERSION    {1'b0, `TURF_FW_DATE, `TURF_VER_MAJOR, `TURF_VER_MINOR, `TURF_VER_REV}

// ID space offsets
`define TURF_REG_IDENT      12'h000
`define TURF_REG_DATEVER    12'h004
`define TURF_REG_SCRATCH    12'h008
`define TURF_REG_GPOCTL     12'h00C

// Time space offsets
`define TURF_REG_CURSEC     12'h000
`define TURF_REG_CURTIME    12'h004
`define TURF_REG_LASTPPS    12'h008

`define TURF_UNMAPPED_DATA  32'hDEADBEEF
`define TURF_GPO_SEL_W      3

`endif

/* turf_ctrl_pkg.sv */
`default_nettype none
`include "turf_ctrl_cfg.svh"

package turf_ctrl_pkg;

    // Request from the register master, full byte address
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`TURF_ADDR_W-1:0] adr;
        logic [`TURF_DATA_W-1:0] dat;
    } wb_req_t;

    // Request as seen by one register space
    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`TURF_SLV_ADDR_W-1:0] adr;
        logic [`TURF_DATA_W-1:0]     dat;
    } wb_slv_req_t;

    // Response, read data valid with ack or err
    typedef struct packed {
        logic                    ack;
        logic                    err;
        logic [`TURF_DATA_W-1:0] dat;
    } wb_rsp_t;

    // General-purpose output control, en sits above sel
    typedef struct packed {
        logic                       en;
        logic [`TURF_GPO_SEL_W-1:0] sel;
    } gpo_ctrl_t;

    // TOUT sources, anything above these drives 0
    typedef enum logic [`TURF_GPO_SEL_W-1:0] {
        GPO_SRC_PPS  = 3'd0,
        GPO_SRC_SEC  = 3'd1,
        GPO_SRC_TIN0 = 3'd2,
        GPO_SRC_TIN1 = 3'd3
    } gpo_src_e;

endpackage

`default_nettype wire

/* turf_wb_intercon.sv */
`timescale 1ns/100ps
`default_nettype none
`include "turf_ctrl_cfg.svh"

module turf_wb_intercon (
    input  wire logic                       ps_clk,
    input  wire logic                       reset_i,
    input  wire turf_ctrl_pkg::wb_req_t     m_req_i,
    output turf_ctrl_pkg::wb_rsp_t          m_rsp_o,
    output turf_ctrl_pkg::wb_slv_req_t      id_req_o,
    output turf_ctrl_pkg::wb_slv_req_t      time_req_o,
    input  wire turf_ctrl_pkg::wb_rsp_t     id_rsp_i,
    input  wire turf_ctrl_pkg::wb_rsp_t     time_rsp_i
);

    import turf_ctrl_pkg::*;

    logic [`TURF_ADDR_W-`TURF_SLV_ADDR_W-1:0] slv_sel;
    logic                                     sel_id;
    logic                                     sel_time;
    logic                                     unm_stb;
    logic                                     unm_err_q;
    logic                                     unm_done_q;
    wb_rsp_t                                  slv_rsp;
    logic                                     rsp_ack_q;
    logic                                     rsp_err_q;
    logic [`TURF_DATA_W-1:0]                  rsp_dat_q;

    // Upper address bits pick the register space
    assign slv_sel  = m_req_i.adr[`TURF_ADDR_W-1:`TURF_SLV_ADDR_W];
    assign sel_id   = (slv_sel == `TURF_SEL_ID);
    assign sel_time = (slv_sel == `TURF_SEL_TIME);
    assign unm_stb  = m_req_i.cyc & m_req_i.stb & ~sel_id & ~sel_time;

    // Only the selected space ever sees stb
    assign id_req_o = '{cyc: m_req_i.cyc,
                        stb: m_req_i.stb & sel_id,
                        we:  m_req_i.we,
                        adr: m_req_i.adr[`TURF_SLV_ADDR_W-1:0],
                        dat: m_req_i.dat};

    assign time_req_o = '{cyc: m_req_i.cyc,
                          stb: m_req_i.stb & sel_time,
                          we:  m_req_i.we,
                          adr: m_req_i.adr[`TURF_SLV_ADDR_W-1:0],
                          dat: m_req_i.dat};

    // Unmapped requests get one err, with the same timing as a slave ack
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            unm_err_q  <= 1'b0;
            unm_done_q <= 1'b0;
        end else begin
            unm_err_q  <= unm_stb & ~unm_done_q;
            unm_done_q <= unm_stb;
        end
    end

    always_comb begin
        if (sel_id) begin
            slv_rsp = id_rsp_i;
        end else if (sel_time) begin
            slv_rsp = time_rsp_i;
        end else begin
            slv_rsp.ack = 1'b0;
            slv_rsp.err = unm_err_q;
            slv_rsp.dat = `TURF_UNMAPPED_DATA;
        end
    end

    // Response register toward the master
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            rsp_ack_q <= 1'b0;
            rsp_err_q <= 1'b0;
        end else begin
            rsp_ack_q <= slv_rsp.ack;
            rsp_err_q <= slv_rsp.err;
        end
    end

    always_ff @(posedge ps_clk) begin
        rsp_dat_q <= slv_rsp.dat;
    end

    assign m_rsp_o = '{ack: rsp_ack_q, err: rsp_err_q, dat: rsp_dat_q};

endmodule

`default_nettype wire

/* turf_id_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "turf_ctrl_cfg.svh"

module turf_id_ctrl (
    input  wire logic                       ps_clk,
    input  wire logic                       reset_i,
    input  wire turf_ctrl_pkg::wb_slv_req_t wb_req_i,
    output turf_ctrl_pkg::wb_rsp_t          wb_rsp_o,
    output turf_ctrl_pkg::gpo_ctrl_t        gpo_ctrl_o
);

    import turf_ctrl_pkg::*;

    localparam int GPO_W = $bits(gpo_ctrl_t);

    logic                    access;
    logic                    ack_q;
    logic                    done_q;
    logic [`TURF_DATA_W-1:0] rd_dat;
    logic [`TURF_DATA_W-1:0] rd_dat_q;
    logic [`TURF_DATA_W-1:0] scratch_q;
    gpo_ctrl_t               gpo_ctrl_q;

    // First cycle of a request, done_q holds off repeats until stb drops
    assign access = wb_req_i.cyc & wb_req_i.stb & ~done_q;

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= access;
            done_q <= wb_req_i.cyc & wb_req_i.stb;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Writable registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            scratch_q  <= '0;
            gpo_ctrl_q <= '0;
        end else if (access && wb_req_i.we) begin
            if (wb_req_i.adr == `TURF_REG_SCRATCH) begin
                scratch_q <= wb_req_i.dat;
            end
            if (wb_req_i.adr == `TURF_REG_GPOCTL) begin
                gpo_ctrl_q <= gpo_ctrl_t'(wb_req_i.dat[GPO_W-1:0]);
            end
        end
    end

    // Read decode, holes read as zero
    always_comb begin
        rd_dat = '0;
        case (wb_req_i.adr)
            `TURF_REG_IDENT:   rd_dat = `TURF_IDENT;
            `TURF_REG_DATEVER: rd_dat = `TURF_DATEVERSION;
            `TURF_REG_SCRATCH: rd_dat = scratch_q;
            `TURF_REG_GPOCTL:  rd_dat[GPO_W-1:0] = gpo_ctrl_q;
            default:           rd_dat = '0;
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (access) begin
            rd_dat_q <= rd_dat;
        end
    end

    assign wb_rsp_o   = '{ack: ack_q, err: 1'b0, dat: rd_dat_q};
    assign gpo_ctrl_o = gpo_ctrl_q;

endmodule

`default_nettype wire

/* pps_timekeeper.sv */
`timescale 1ns/100ps
`default_nettype none
`include "turf_ctrl_cfg.svh"

module pps_timekeeper (
    input  wire logic                       ps_clk,
    input  wire logic                       reset_i,
    input  wire turf_ctrl_pkg::wb_slv_req_t wb_req_i,
    output turf_ctrl_pkg::wb_rsp_t          wb_rsp_o,
    input  wire logic                       pps_i,
    output logic                            pps_pulse_o,
    output logic                            sec_lsb_o
);

    import turf_ctrl_pkg::*;

    logic                    pps_s1_q;
    logic                    pps_s2_q;
    logic                    pps_s3_q;
    logic                    pulse_q;
    logic                    access;
    logic                    wr_cursec;
    logic                    ack_q;
    logic                    done_q;
    logic [`TURF_DATA_W-1:0] cur_sec_q;
    logic [`TURF_DATA_W-1:0] cur_time_q;
    logic [`TURF_DATA_W-1:0] last_pps_q;
    logic [`TURF_DATA_W-1:0] rd_dat;
    logic [`TURF_DATA_W-1:0] rd_dat_q;

    //////////////////////////////////////////////////////////////////////
    // PPS input synchronizer and rising edge
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            pps_s1_q <= 1'b0;
            pps_s2_q <= 1'b0;
            pps_s3_q <= 1'b0;
            pulse_q  <= 1'b0;
        end else begin
            pps_s1_q <= pps_i;
            pps_s2_q <= pps_s1_q;
            pps_s3_q <= pps_s2_q;
            pulse_q  <= pps_s2_q & ~pps_s3_q;
        end
    end

    // Bus handshake, one ack per request
    assign access    = wb_req_i.cyc & wb_req_i.stb & ~done_q;
    assign wr_cursec = access & wb_req_i.we & (wb_req_i.adr == `TURF_REG_CURSEC);

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= access;
            done_q <= wb_req_i.cyc & wb_req_i.stb;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Seconds and tick counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            cur_sec_q  <= '0;
            cur_time_q <= '0;
            last_pps_q <= '0;
        end else begin
            // A load that lands on a PPS still counts that edge
            if (wr_cursec) begin
                cur_sec_q <= wb_req_i.dat + {{(`TURF_DATA_W-1){1'b0}}, pulse_q};
            end else if (pulse_q) begin
                cur_sec_q <= cur_sec_q + 1'b1;
            end
            if (pulse_q) begin
                last_pps_q <= cur_time_q + 1'b1;
                cur_time_q <= '0;
            end else begin
                cur_time_q <= cur_time_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (wb_req_i.adr)
            `TURF_REG_CURSEC:  rd_dat = cur_sec_q;
            `TURF_REG_CURTIME: rd_dat = cur_time_q;
            `TURF_REG_LASTPPS: rd_dat = last_pps_q;
            default:           rd_dat = '0;
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (access) begin
            rd_dat_q <= rd_dat;
        end
    end

    assign wb_rsp_o    = '{ack: ack_q, err: 1'b0, dat: rd_dat_q};
    assign pps_pulse_o = pulse_q;
    assign sec_lsb_o   = cur_sec_q[0];

endmodule

`default_nettype wire

/* turf_gpo_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module turf_gpo_mux (
    input  wire logic                     ps_clk,
    input  wire logic                     reset_i,
    input  wire turf_ctrl_pkg::gpo_ctrl_t gpo_ctrl_i,
    input  wire logic                     pps_pulse_i,
    input  wire logic                     sec_lsb_i,
    input  wire logic [1:0]               tin_i,
    output logic                          gpo_o
);

    import turf_ctrl_pkg::*;

    logic src;

    // Source pick, unused selects give a quiet pin
    always_comb begin
        case (gpo_ctrl_i.sel)
            GPO_SRC_PPS:  src = pps_pulse_i;
            GPO_SRC_SEC:  src = sec_lsb_i;
            GPO_SRC_TIN0: src = tin_i[0];
            GPO_SRC_TIN1: src = tin_i[1];
            default:      src = 1'b0;
        endcase
    end

    // Output flop, held low while disabled
    always_ff @(posedge ps_clk) begin
        if (reset_i) begin
            gpo_o <= 1'b0;
        end else begin
            gpo_o <= gpo_ctrl_i.en & src;
        end
    end

endmodule

`default_nettype wire

/* turf_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module turf_ctrl_top (
    input  wire logic                    ps_clk,
    input  wire logic                    reset_i,
    input  wire turf_ctrl_pkg::wb_req_t  bus_req_i,
    output turf_ctrl_pkg::wb_rsp_t       bus_rsp_o,
    input  wire logic                    pps_i,
    input  wire logic [1:0]              tin_i,
    output logic                         tout_o
);

    import turf_ctrl_pkg::*;

    wb_slv_req_t id_req;
    wb_slv_req_t time_req;
    wb_rsp_t     id_rsp;
    wb_rsp_t     time_rsp;
    gpo_ctrl_t   gpo_ctrl;
    logic        pps_pulse;
    logic        sec_lsb;

    //////////////////////////////////////////////////////////////////////
    // Register interconnect
    //////////////////////////////////////////////////////////////////////

    turf_wb_intercon u_intercon (
        .ps_clk     (ps_clk),
        .reset_i    (reset_i),
        .m_req_i    (bus_req_i),
        .m_rsp_o    (bus_rsp_o),
        .id_req_o   (id_req),
        .time_req_o (time_req),
        .id_rsp_i   (id_rsp),
        .time_rsp_i (time_rsp)
    );

    //////////////////////////////////////////////////////////////////////
    // Register spaces
    //////////////////////////////////////////////////////////////////////

    turf_id_ctrl u_idctrl (
        .ps_clk     (ps_clk),
        .reset_i    (reset_i),
        .wb_req_i   (id_req),
        .wb_rsp_o   (id_rsp),
        .gpo_ctrl_o (gpo_ctrl)
    );

    pps_timekeeper u_time (
        .ps_clk      (ps_clk),
        .reset_i     (reset_i),
        .wb_req_i    (time_req),
        .wb_rsp_o    (time_rsp),
        .pps_i       (pps_i),
        .pps_pulse_o (pps_pulse),
        .sec_lsb_o   (sec_lsb)
    );

    // TOUT pin driver
    turf_gpo_mux u_mux (
        .ps_clk      (ps_clk),
        .reset_i     (reset_i),
        .gpo_ctrl_i  (gpo_ctrl),
        .pps_pulse_i (pps_pulse),
        .sec_lsb_i   (sec_lsb),
        .tin_i       (tin_i),
        .gpo_o       (tout_o)
    );

endmodule

`default_nettype wire

/* tb_turf_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "turf_ctrl_cfg.svh"

module tb_turf_ctrl;

    import turf_ctrl_pkg::*;

    localparam int MAX_CYCLES = 20000;

    localparam logic [15:0] ADR_IDENT   = {`TURF_SEL_ID, `TURF_REG_IDENT};
    localparam logic [15:0] ADR_DATEVER = {`TURF_SEL_ID, `TURF_REG_DATEVER};
    localparam logic [15:0] ADR_SCRATCH = {`TURF_SEL_ID, `TURF_REG_SCRATCH};
    localparam logic [15:0] ADR_GPOCTL  = {`TURF_SEL_ID, `TURF_REG_GPOCTL};
    localparam logic [15:0] ADR_CURSEC  = {`TURF_SEL_TIME, `TURF_REG_CURSEC};
    localparam logic [15:0] ADR_LASTPPS = {`TURF_SEL_TIME, `TURF_REG_LASTPPS};

    // Date in bits 30..16, major 15..12, minor 11..8, revision 7..0, bit 31 clear
    localparam logic [31:0] EXP_DATEVER = (32'(`TURF_FW_DATE) << 16)
                                        | (32'(`TURF_VER_MAJOR) << 12)
                                        | (32'(`TURF_VER_MINOR) << 8)
                                        | 32'(`TURF_VER_REV);

    logic        ps_clk;
    logic        reset_i;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    logic        pps_i;
    logic [1:0]  tin_i;
    logic        tout_o;

    logic [15:0] lfsr;
    int          cyc_cnt;
    int          err_cnt;
    int          test_err_base;
    int          tests_run;
    int          tests_failed;
    logic        chk_on;

    // Reference model state
    logic [31:0] m_scratch;
    gpo_ctrl_t   m_gpo;
    logic [31:0] m_sec;
    logic [31:0] m_ticks;
    logic [31:0] m_last;
    logic [3:0]  m_hist;
    logic        exp_tout;

    turf_ctrl_top UUT (
        .ps_clk    (ps_clk),
        .reset_i   (reset_i),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .pps_i     (pps_i),
        .tin_i     (tin_i),
        .tout_o    (tout_o)
    );

    always #5 ps_clk = ~ps_clk;

    always @(posedge ps_clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= MAX_CYCLES) begin
            $display("Run stopped at the cycle limit of %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Cycle model of the PPS counters and the TOUT pin
    //////////////////////////////////////////////////////////////////////

    // Runs mid-cycle, when DUT outputs and driven inputs are both settled
    always @(negedge ps_clk) begin
        logic pulse;
        logic src;
        // Edge driven three cycles back shows as a one-cycle pulse now
        pulse = m_hist[2] & ~m_hist[3];
        if (chk_on && tout_o !== exp_tout) begin
            $display("FAIL tout_o expected %h got %h at cycle %0d", exp_tout, tout_o, cyc_cnt);
            err_cnt = err_cnt + 1;
        end
        case (m_gpo.sel)
            3'd0:    src = pulse;
            3'd1:    src = m_sec[0];
            3'd2:    src = tin_i[0];
            3'd3:    src = tin_i[1];
            default: src = 1'b0;
        endcase
        if (reset_i) begin
            exp_tout = 1'b0;
            m_ticks  = '0;
            m_last   = '0;
            m_sec    = '0;
            m_hist   = '0;
        end else begin
            exp_tout = m_gpo.en & src;
            if (pulse) begin
                m_last  = m_ticks + 32'd1;
                m_ticks = '0;
                m_sec   = m_sec + 32'd1;
            end else begin
                m_ticks = m_ticks + 32'd1;
            end
            m_hist = {m_hist[2:0], pps_i};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge ps_clk);
            #1;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("FAIL %s expected %h got %h", name, exp_v, act_v);
            err_cnt = err_cnt + 1;
        end
    endtask

    // Register writes land on the first clock edge of the request
    task automatic model_write(input logic [15:0] adr, input logic [31:0] dat);
        if (adr == ADR_SCRATCH) begin
            m_scratch = dat;
        end
        if (adr == ADR_GPOCTL) begin
            m_gpo = gpo_ctrl_t'(dat[3:0]);
        end
        if (adr == ADR_CURSEC) begin
            m_sec = dat;
        end
    endtask

    task automatic bus_xfer(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                            input logic exp_err, output logic [31:0] rdat);
        int   n;
        logic got_ack;
        logic got_err;
        n = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        // One idle cycle with stb low between requests
        wait_cycles(1);
        bus_req.cyc = 1'b1;
        bus_req.stb = 1'b1;
        bus_req.we  = we;
        bus_req.adr = adr;
        bus_req.dat = dat;
        while (!got_ack && !got_err && n < 16) begin
            @(posedge ps_clk);
            #1;
            n = n + 1;
            if (n == 1 && we) begin
                model_write(adr, dat);
            end
            got_ack = bus_rsp.ack;
            got_err = bus_rsp.err;
        end
        rdat = bus_rsp.dat;
        bus_req.cyc = 1'b0;
        bus_req.stb = 1'b0;
        bus_req.we  = 1'b0;
        if (!got_ack && !got_err) begin
            $display("Bus request to address %h got neither ack nor err", adr);
            err_cnt = err_cnt + 1;
        end else begin
            if (n != 2) begin
                $display("FAIL bus_rsp_o latency expected %h got %h", 2, n);
                err_cnt = err_cnt + 1;
            end
            if (got_ack !== !exp_err || got_err !== exp_err) begin
                $display("FAIL bus_rsp_o.err expected %h got %h (ack %h) at address %h",
                         exp_err, got_err, got_ack, adr);
                err_cnt = err_cnt + 1;
            end
        end
    endtask

    task automatic bus_write(input logic [15:0] adr, input logic [31:0] dat);
        logic [31:0] rd;
        bus_xfer(1'b1, adr, dat, 1'b0, rd);
    endtask

    task automatic check_read(input string name, input logic [15:0] adr,
                              input logic [31:0] exp_v);
        logic [31:0] rd;
        bus_xfer(1'b0, adr, '0, 1'b0, rd);
        check_word(name, exp_v, rd);
    endtask

    task automatic end_test(input string name);
        tests_run = tests_run + 1;
        if (err_cnt != test_err_base) begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %s finished with %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          i;
        int          k;
        int          gap;
        int          edge_cyc;
        logic [31:0] val;
        logic [31:0] rd;
        logic [3:0]  sel;
        logic        we_r;
        ps_clk = 1'b0;
        reset_i = 1'b1;
        bus_req = '0;
        pps_i = 1'b0;
        tin_i = 2'b00;
        lfsr = 16'd60938;
        cyc_cnt = 0;
        err_cnt = 0;
        test_err_base = 0;
        tests_run = 0;
        tests_failed = 0;
        chk_on = 1'b0;
        m_scratch = '0;
        m_gpo = '0;
        exp_tout = 1'b0;
        wait_cycles(4);
        reset_i = 1'b0;
        chk_on = 1'b1;

        check_read("IDENT", ADR_IDENT, `TURF_IDENT);
        check_read("DATEVER", ADR_DATEVER, EXP_DATEVER);
        end_test("ident");

        for (i = 0; i < 20; i++) begin
            bus_write(ADR_SCRATCH, rand_bits(32));
            check_read("SCRATCH", ADR_SCRATCH, m_scratch);
        end
        bus_write(ADR_IDENT, rand_bits(32));
        check_read("IDENT", ADR_IDENT, `TURF_IDENT);
        end_test("scratch");

        // Selects 2 to 15 hit no register space
        for (i = 0; i < 8; i++) begin
            sel = 4'(2 + rand_bits(4) % 14);
            val = rand_bits(12);
            we_r = (rand_bits(1) != 0);
            bus_xfer(we_r, {sel, val[11:0]}, rand_bits(32), 1'b1, rd);
            check_word("bus_rsp_o.dat", `TURF_UNMAPPED_DATA, rd);
        end
        end_test("unmapped");

        val = rand_bits(32);
        bus_write(ADR_CURSEC, val);
        for (k = 1; k <= 5; k++) begin
            gap = 20 + int'(rand_bits(8) % 181);
            edge_cyc = cyc_cnt;
            pps_i = 1'b1;
            wait_cycles(4);
            check_read("CURSEC", ADR_CURSEC, val + k);
            if (k > 1) begin
                check_read("LASTPPS", ADR_LASTPPS, m_last);
            end
            pps_i = 1'b0;
            while (cyc_cnt - edge_cyc < gap) begin
                wait_cycles(1);
            end
        end
        wait_cycles(8);
        end_test("pps");

        // Walk every select, enabled in the first half and mixed after
        for (i = 0; i < 16; i++) begin
            val = rand_bits(32);
            val[2:0] = i[2:0];
            if (i < 8) begin
                val[3] = 1'b1;
            end else if (i == 8) begin
                val[3] = 1'b0;
            end
            bus_write(ADR_GPOCTL, val);
            check_read("GPOCTL", ADR_GPOCTL, {28'h0, m_gpo});
            pps_i = 1'b1;
            for (k = 0; k < 30; k++) begin
                tin_i = 2'(rand_bits(2));
                if (k == 8) begin
                    pps_i = 1'b0;
                end
                wait_cycles(1);
            end
        end
        check_read("CURSEC", ADR_CURSEC, m_sec);
        end_test("gpo");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* turf_ctrl_top.f */
+incdir+.
turf_ctrl_pkg.sv
turf_wb_intercon.sv
turf_id_ctrl.sv
pps_timekeeper.sv
turf_gpo_mux.sv
turf_ctrl_top.sv
tb_turf_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_turf_ctrl \
    -f turf_ctrl_top.f \
    -o sim_tb_turf_ctrl

out="$(./obj_dir/sim_tb_turf_ctrl)"
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
else
    exit 1
fi
